/* logic/gat_pkg.sv */
package gat_pkg;

  // datapath samples.
  typedef logic signed [15:0] feat_t;
  typedef logic signed [31:0] prod_t;
  typedef logic signed [31:0] acc_t; // wraps modulo 2^32.

  // sticky stream levels, in_vld is the msb.
  typedef struct packed {
    logic in_vld;
    logic in_rdy;
    logic prod_vld;
    logic prod_rdy;
    logic res_vld;
    logic res_rdy;
  } hs_flags_t;

  typedef struct packed {
    hs_flags_t   flags;
    logic [31:0] result_cnt;
    prod_t       capture;
  } dbg_status_t;

  // wishbone classic request and response.
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [3:0]  adr;
    logic [31:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  // register map, word addresses.
  localparam logic [3:0] REG_ID      = 4'd0;
  localparam logic [3:0] REG_WEIGHT  = 4'd1;
  localparam logic [3:0] REG_CAP_IDX = 4'd2;
  localparam logic [3:0] REG_FLAGS   = 4'd3;
  localparam logic [3:0] REG_RES_CNT = 4'd4;
  localparam logic [3:0] REG_CAPTURE = 4'd5;
  localparam logic [3:0] REG_CTRL    = 4'd6;

  localparam logic [31:0] DBG_ID = 32'h6A71_0001;

endpackage

/* logic/pipe_reg.sv */
`timescale 1ns/100ps

module pipe_reg #(
  parameter type T = logic [31:0]
) (
  input  logic clk,
  input  logic rst_n,

  input  logic in_vld_i,
  input  T     in_data_i,
  output logic in_rdy_o,

  output logic out_vld_o,
  output T     out_data_o,
  input  logic out_rdy_i
);

  logic full_q;
  T     data_q;
  logic load;

  // take new data when empty or when the current entry leaves this cycle.
  assign in_rdy_o = !full_q || out_rdy_i;
  assign load     = in_vld_i && in_rdy_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full_q <= 1'b0;
    end else if (load) begin
      full_q <= 1'b1;
    end else if (out_rdy_i) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      data_q <= in_data_i;
    end
  end

  assign out_vld_o  = full_q;
  assign out_data_o = data_q;

endmodule

/* logic/dmvm_unit.sv */
`timescale 1ns/100ps

module dmvm_unit import gat_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,

  input  feat_t weight_i,

  input  logic  feat_vld_i,
  input  feat_t feat_i,
  output logic  feat_rdy_o,

  output logic  prod_vld_o,
  output prod_t prod_o,
  input  logic  prod_rdy_i
);

  prod_t prod_d;
  prod_t feat_ext;
  prod_t weight_ext;

  // sign extend both operands, the product fits in 32 bits.
  assign feat_ext   = prod_t'(feat_i);
  assign weight_ext = prod_t'(weight_i);
  assign prod_d     = feat_ext * weight_ext; // weight taken with the feature.

  pipe_reg #(
    .T (prod_t)
  ) u_prod_reg (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_vld_i   (feat_vld_i),
    .in_data_i  (prod_d),
    .in_rdy_o   (feat_rdy_o),
    .out_vld_o  (prod_vld_o),
    .out_data_o (prod_o),
    .out_rdy_i  (prod_rdy_i)
  );

endmodule

/* logic/aggr_unit.sv */
`timescale 1ns/100ps

module aggr_unit import gat_pkg::*; #(
  parameter int NUM_NEIGHBORS = 4
) (
  input  logic  clk,
  input  logic  rst_n,

  input  logic  prod_vld_i,
  input  prod_t prod_i,
  output logic  prod_rdy_o,

  output logic  res_vld_o,
  output acc_t  res_o,
  input  logic  res_rdy_i
);

  localparam int CNT_W = (NUM_NEIGHBORS > 1) ? $clog2(NUM_NEIGHBORS) : 1;
  localparam logic [CNT_W-1:0] LAST = CNT_W'(NUM_NEIGHBORS - 1);

  logic [CNT_W-1:0] nbr_cnt_q;
  acc_t             acc_q;
  logic             res_vld_q;
  prod_t            act;
  logic             accept;

  // leaky activation, negative values floor-shifted by 3.
  assign act = prod_i[31] ? (prod_i >>> 3) : prod_i;

  assign prod_rdy_o = !res_vld_q; // stall while a sum waits.
  assign accept     = prod_vld_i && prod_rdy_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      nbr_cnt_q <= '0;
      acc_q     <= '0;
      res_vld_q <= 1'b0;
    end else if (accept) begin
      acc_q <= acc_q + act;
      if (nbr_cnt_q == LAST) begin
        nbr_cnt_q <= '0;
        res_vld_q <= 1'b1;
      end else begin
        nbr_cnt_q <= nbr_cnt_q + 1'b1;
      end
    end else if (res_vld_q && res_rdy_i) begin
      res_vld_q <= 1'b0;
      acc_q     <= '0; // next node starts from zero.
    end
  end

  assign res_vld_o = res_vld_q;
  assign res_o     = acc_q;

endmodule

/* logic/debugger.sv */
`timescale 1ns/100ps

module debugger import gat_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        clear_i,

  input  logic [31:0] cap_idx_i,

  input  hs_flags_t   flags_i,
  input  prod_t       prod_i,

  output dbg_status_t status_o
);

  hs_flags_t   flags_q;
  logic [31:0] result_cnt_q;
  logic [31:0] prod_ord_q;
  prod_t       capture_q;
  logic        res_hs;
  logic        prod_hs;

  assign res_hs  = flags_i.res_vld && flags_i.res_rdy;
  assign prod_hs = flags_i.prod_vld && flags_i.prod_rdy;

  // flags stick once seen high.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags_q <= '0;
    end else if (clear_i) begin
      flags_q <= '0;
    end else begin
      flags_q <= flags_q | flags_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result_cnt_q <= '0;
    end else if (clear_i) begin
      result_cnt_q <= '0;
    end else if (res_hs) begin
      result_cnt_q <= result_cnt_q + 1'b1;
    end
  end

  // product ordinal counts from zero since the last clear.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prod_ord_q <= '0;
      capture_q  <= '0;
    end else if (clear_i) begin
      prod_ord_q <= '0;
      capture_q  <= '0;
    end else if (prod_hs) begin
      prod_ord_q <= prod_ord_q + 1'b1;
      if (prod_ord_q == cap_idx_i) begin
        capture_q <= prod_i;
      end
    end
  end

  always_comb begin
    status_o            = '0;
    status_o.flags      = flags_q;
    status_o.result_cnt = result_cnt_q;
    status_o.capture    = capture_q;
  end

endmodule

/* logic/gat_csr.sv */
`timescale 1ns/100ps

module gat_csr import gat_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,

  input  wb_req_t     wb_req_i,
  output wb_rsp_t     wb_rsp_o,

  input  dbg_status_t status_i,

  output feat_t       weight_o,
  output logic [31:0] cap_idx_o,
  output logic        clear_o
);

  logic        ack_q;
  logic        req;
  feat_t       weight_q;
  logic [31:0] cap_idx_q;
  logic        clear_q;
  logic [31:0] rd_dat;

  // new request only when no ack is pending, so ack lasts one cycle.
  assign req = wb_req_i.cyc && wb_req_i.stb && !ack_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_q     <= 1'b0;
      weight_q  <= 16'sd1;
      cap_idx_q <= '0;
      clear_q   <= 1'b0;
    end else begin
      ack_q   <= req;
      clear_q <= 1'b0;
      if (req && wb_req_i.we) begin
        case (wb_req_i.adr)
          REG_WEIGHT:  weight_q  <= feat_t'(wb_req_i.dat[15:0]);
          REG_CAP_IDX: cap_idx_q <= wb_req_i.dat;
          REG_CTRL:    clear_q   <= wb_req_i.dat[0]; // one-cycle pulse.
          default:     ;
        endcase
      end
    end
  end

  // master holds adr until ack, so the mux is valid in the ack cycle.
  always_comb begin
    case (wb_req_i.adr)
      REG_ID:      rd_dat = DBG_ID;
      REG_WEIGHT:  rd_dat = {{16{weight_q[15]}}, weight_q};
      REG_CAP_IDX: rd_dat = cap_idx_q;
      REG_FLAGS:   rd_dat = {26'd0, status_i.flags};
      REG_RES_CNT: rd_dat = status_i.result_cnt;
      REG_CAPTURE: rd_dat = status_i.capture;
      default:     rd_dat = '0;
    endcase
  end

  always_comb begin
    wb_rsp_o.ack = ack_q;
    wb_rsp_o.dat = (ack_q && !wb_req_i.we) ? rd_dat : '0;
  end

  assign weight_o  = weight_q;
  assign cap_idx_o = cap_idx_q;
  assign clear_o   = clear_q;

endmodule

/* logic/gat_top.sv */
`timescale 1ns/100ps

module gat_top import gat_pkg::*; #(
  parameter int NUM_NEIGHBORS = 4
) (
  input  logic    clk,
  input  logic    rst_n,

  input  logic    feat_vld_i,
  input  feat_t   feat_i,
  output logic    feat_rdy_o,

  output logic    res_vld_o,
  output acc_t    res_o,
  input  logic    res_rdy_i,

  input  wb_req_t wb_req_i,
  output wb_rsp_t wb_rsp_o
);

  feat_t       weight;
  logic [31:0] cap_idx;
  logic        clear;
  dbg_status_t status;
  hs_flags_t   flags;

  logic        prod_vld;
  prod_t       prod;
  logic        prod_rdy;
  logic        sum_vld;
  acc_t        sum;
  logic        sum_rdy;

  dmvm_unit u_dmvm (
    .clk        (clk),
    .rst_n      (rst_n),
    .weight_i   (weight),
    .feat_vld_i (feat_vld_i),
    .feat_i     (feat_i),
    .feat_rdy_o (feat_rdy_o),
    .prod_vld_o (prod_vld),
    .prod_o     (prod),
    .prod_rdy_i (prod_rdy)
  );

  aggr_unit #(
    .NUM_NEIGHBORS (NUM_NEIGHBORS)
  ) u_aggr (
    .clk        (clk),
    .rst_n      (rst_n),
    .prod_vld_i (prod_vld),
    .prod_i     (prod),
    .prod_rdy_o (prod_rdy),
    .res_vld_o  (sum_vld),
    .res_o      (sum),
    .res_rdy_i  (sum_rdy)
  );

  // output register, one more cycle of latency.
  pipe_reg #(
    .T (acc_t)
  ) u_res_reg (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_vld_i   (sum_vld),
    .in_data_i  (sum),
    .in_rdy_o   (sum_rdy),
    .out_vld_o  (res_vld_o),
    .out_data_o (res_o),
    .out_rdy_i  (res_rdy_i)
  );

  always_comb begin
    flags.in_vld   = feat_vld_i;
    flags.in_rdy   = feat_rdy_o;
    flags.prod_vld = prod_vld;
    flags.prod_rdy = prod_rdy;
    flags.res_vld  = res_vld_o; // result levels seen at the ports.
    flags.res_rdy  = res_rdy_i;
  end

  debugger u_debugger (
    .clk       (clk),
    .rst_n     (rst_n),
    .clear_i   (clear),
    .cap_idx_i (cap_idx),
    .flags_i   (flags),
    .prod_i    (prod),
    .status_o  (status)
  );

  gat_csr u_csr (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_req_i  (wb_req_i),
    .wb_rsp_o  (wb_rsp_o),
    .status_i  (status),
    .weight_o  (weight),
    .cap_idx_o (cap_idx),
    .clear_o   (clear)
  );

endmodule

/* sim/gat_checker.sv */
`timescale 1ns/100ps

module gat_checker import gat_pkg::*; (
  input logic    clk,
  input logic    rst_n,
  input logic    feat_vld_i,
  input feat_t   feat_i,
  input logic    feat_rdy_o,
  input logic    res_vld_o,
  input acc_t    res_o,
  input logic    res_rdy_i,
  input wb_req_t wb_req_i,
  input wb_rsp_t wb_rsp_o
);

  // a stalled transfer keeps its valid and its data.
  a_feat_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (feat_vld_i && !feat_rdy_o) |=> (feat_vld_i && $stable(feat_i)))
    else $error("feature stream changed while stalled");

  a_res_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (res_vld_o && !res_rdy_i) |=> (res_vld_o && $stable(res_o)))
    else $error("result stream changed while stalled");

  a_ack_single: assert property (@(posedge clk) disable iff (!rst_n)
    wb_rsp_o.ack |=> !wb_rsp_o.ack)
    else $error("wishbone ack held longer than one cycle");

  a_ack_req: assert property (@(posedge clk) disable iff (!rst_n)
    wb_rsp_o.ack |-> (wb_req_i.cyc && wb_req_i.stb))
    else $error("wishbone ack without cyc and stb");

endmodule

bind gat_top gat_checker u_checker (
  .clk        (clk),
  .rst_n      (rst_n),
  .feat_vld_i (feat_vld_i),
  .feat_i     (feat_i),
  .feat_rdy_o (feat_rdy_o),
  .res_vld_o  (res_vld_o),
  .res_o      (res_o),
  .res_rdy_i  (res_rdy_i),
  .wb_req_i   (wb_req_i),
  .wb_rsp_o   (wb_rsp_o)
);

/* sim/gat_tb.sv */
`timescale 1ns/100ps

module gat_tb import gat_pkg::*; ();

  localparam int NUM_NEIGHBORS = 4;
  localparam int NUM_GROUPS    = 40;
  localparam int NUM_FEATS     = NUM_GROUPS * NUM_NEIGHBORS;
  localparam int WAIT_LIMIT    = 200;
  localparam logic [31:0] IDLE_MASK = 32'h0000_002B; // in_vld, prod_vld, res_vld, res_rdy.

  logic        clk;
  logic        rst_n;
  logic        feat_vld_i;
  feat_t       feat_i;
  logic        feat_rdy_o;
  logic        res_vld_o;
  acc_t        res_o;
  logic        res_rdy_i;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;

  feat_t       feats [NUM_FEATS];
  prod_t       prods [NUM_FEATS];
  acc_t        exp_q [$];
  feat_t       weight;
  logic [31:0] cap_idx;
  int          rx_cnt;
  int          err_cnt;
  int          chk_cnt;

  gat_top #(
    .NUM_NEIGHBORS (NUM_NEIGHBORS)
  ) u_gat_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .feat_vld_i (feat_vld_i),
    .feat_i     (feat_i),
    .feat_rdy_o (feat_rdy_o),
    .res_vld_o  (res_vld_o),
    .res_o      (res_o),
    .res_rdy_i  (res_rdy_i),
    .wb_req_i   (wb_req),
    .wb_rsp_o   (wb_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic timeout_abort(input string what);
    $display("timeout: %s did not complete within %0d cycles", what, WAIT_LIMIT);
    $display("test failed");
    $finish;
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp_val);
    chk_cnt++;
    if (got !== exp_val) begin
      $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp_val);
      err_cnt++;
    end
  endtask

  task automatic report_test(input int num, input string name, input int err_before);
    $display("check %0d %s: %0d errors", num, name, err_cnt - err_before);
  endtask

  // one classic cycle, request held through the ack cycle.
  task automatic wb_access(input logic we, input logic [3:0] adr, input logic [31:0] wdat,
                           output logic [31:0] rdat);
    int waited;
    @(negedge clk);
    wb_req     = '0;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = wdat;
    waited     = 0;
    do begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT) timeout_abort("wishbone access");
    end while (!wb_rsp.ack);
    rdat = wb_rsp.dat;
    @(negedge clk); // the slave samples the end of the cycle at this edge.
    wb_req = '0;
  endtask

  task automatic wb_write(input logic [3:0] adr, input logic [31:0] dat);
    logic [31:0] discard;
    wb_access(1'b1, adr, dat, discard);
  endtask

  task automatic wb_read(input logic [3:0] adr, output logic [31:0] dat);
    wb_access(1'b0, adr, 32'd0, dat);
  endtask

  // floor of p / 8 for negative values.
  function automatic prod_t leaky_act(input prod_t p);
    longint wide;
    wide = longint'(p);
    if (wide < 0) begin
      wide = (wide - 7) / 8;
    end
    return prod_t'(wide);
  endfunction

  task automatic build_model();
    longint sum;
    longint prod;
    sum = 0;
    for (int i = 0; i < NUM_FEATS; i++) begin
      feats[i] = feat_t'($urandom);
      prod     = longint'(feats[i]) * longint'(weight);
      prods[i] = prod_t'(prod);
      sum      = sum + longint'(leaky_act(prods[i]));
      if ((i % NUM_NEIGHBORS) == NUM_NEIGHBORS - 1) begin
        exp_q.push_back(acc_t'(sum)); // low 32 bits, wrapping.
        sum = 0;
      end
    end
  endtask

  task automatic send_feats();
    int   waited;
    int   gap;
    logic hs;
    @(negedge clk);
    for (int i = 0; i < NUM_FEATS; i++) begin
      gap = ($urandom % 3 == 0) ? int'($urandom % 4) : 0;
      if (gap > 0) begin
        feat_vld_i = 1'b0;
        repeat (gap) @(negedge clk);
      end
      feat_vld_i = 1'b1;
      feat_i     = feats[i];
      waited     = 0;
      hs         = feat_rdy_o; // ready depends on registers only.
      while (!hs) begin
        @(negedge clk);
        waited++;
        if (waited > WAIT_LIMIT) timeout_abort("feature handshake");
        hs = feat_rdy_o;
      end
      @(negedge clk);
    end
    feat_vld_i = 1'b0;
  endtask

  task automatic collect_results();
    int   waited;
    acc_t exp_sum;
    waited = 0;
    while (rx_cnt < NUM_GROUPS) begin
      @(negedge clk);
      res_rdy_i = ($urandom % 4) != 0;
      if (res_vld_o && res_rdy_i) begin
        exp_sum = exp_q.pop_front();
        check_val("res_o", res_o, exp_sum);
        rx_cnt++;
        waited = 0;
      end else begin
        waited++;
        if (waited > WAIT_LIMIT) timeout_abort("result stream");
      end
    end
    @(negedge clk);
    res_rdy_i = 1'b0;
  endtask

  initial begin
    logic [31:0] rd;
    int          err_before;
    void'($urandom(25));
    rst_n      = 1'b0;
    feat_vld_i = 1'b0;
    feat_i     = '0;
    res_rdy_i  = 1'b0;
    wb_req     = '0;
    err_cnt    = 0;
    chk_cnt    = 0;
    rx_cnt     = 0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    err_before = err_cnt;
    wb_read(REG_ID, rd);
    check_val("REG_ID", rd, DBG_ID);
    wb_read(REG_FLAGS, rd);
    check_val("REG_FLAGS idle bits", rd & IDLE_MASK, 32'd0); // ready levels are high at idle.
    wb_read(REG_RES_CNT, rd);
    check_val("REG_RES_CNT", rd, 32'd0);
    wb_read(REG_CAPTURE, rd);
    check_val("REG_CAPTURE", rd, 32'd0);
    report_test(1, "registers after reset", err_before);

    err_before = err_cnt;
    weight     = feat_t'($urandom);
    cap_idx    = $urandom % NUM_FEATS;
    wb_write(REG_WEIGHT, {16'd0, weight});
    wb_write(REG_CAP_IDX, cap_idx);
    build_model();
    fork
      send_feats();
      collect_results();
    join
    report_test(2, "random groups under back-pressure", err_before);

    err_before = err_cnt;
    wb_read(REG_RES_CNT, rd);
    check_val("REG_RES_CNT", rd, rx_cnt);
    report_test(3, "result count", err_before);

    err_before = err_cnt;
    wb_read(REG_CAPTURE, rd);
    check_val("REG_CAPTURE", rd, prods[cap_idx]);
    report_test(4, "product capture", err_before);

    err_before = err_cnt;
    wb_read(REG_FLAGS, rd);
    check_val("REG_FLAGS", rd, 32'h0000_003F);
    wb_write(REG_CTRL, 32'd1);
    wb_read(REG_FLAGS, rd);
    check_val("REG_FLAGS idle bits", rd & IDLE_MASK, 32'd0);
    wb_read(REG_RES_CNT, rd);
    check_val("REG_RES_CNT", rd, 32'd0);
    report_test(5, "flags and clear", err_before);

    $display("checks: %0d, errors: %0d, results: %0d", chk_cnt, err_cnt, rx_cnt);
    if (err_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* files.f */
logic/gat_pkg.sv
logic/pipe_reg.sv
logic/dmvm_unit.sv
logic/aggr_unit.sv
logic/debugger.sv
logic/gat_csr.sv
logic/gat_top.sv
sim/gat_checker.sv
sim/gat_tb.sv

/* run.sh */
#!/bin/sh
# build and run the gat testbench with verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module gat_tb -f files.f -o gat_sim

./obj_dir/gat_sim 2>&1 | tee sim.log

if grep -q "test failed" sim.log || ! grep -q "test passed" sim.log; then
  echo "simulation reported failure, see sim.log"
  exit 1
fi
echo "simulation finished without failure"
